/* fifoBist.sv */
module fifoBist #(
        parameter int fifoWidth = 4
) (
        input  logic                           Data_Rdy,
        input  logic                           Pop_Data,
        input  logic                           bistStart,
        input  logic [uartRxPkg::byteBits-1:0] dataOut,
        input  logic                           fifoEmpty,
        input  logic                           fifoFull,
        output logic                           bistMode,
        output logic                           testWr,
        output logic [uartRxPkg::byteBits-1:0] testData,
        output logic                           testPop,
        output logic                           bistBusy,
        output logic                           bistDone,
        output logic                           bistPass
);

        // Sequencer phases
        localparam logic [2:0] phIdle  = 3'd0;
        localparam logic [2:0] phWrite = 3'd1;          // One write per entry
        localparam logic [2:0] phCheck = 3'd2;          // Full flag check
        localparam logic [2:0] phPop   = 3'd3;          // One pop per entry
        localparam logic [2:0] phCmp   = 3'd4;          // Last byte compare
        localparam logic [2:0] phEnd   = 3'd5;          // Empty flag check

        logic [2:0] phase;
        logic [fifoWidth-1:0] idx;                      // Entry index, wraps after the last
        logic failReg;                                  // Any mismatch so far
        logic [uartRxPkg::byteBits-1:0] expByte;        // Byte the FIFO should show now
        logic byteBad;

        ////////////////////////////////////////
        // Pattern and compare
        ////////////////////////////////////////

        assign testData = uartRxPkg::bistPattern ^ uartRxPkg::byteBits'(idx);
        // dataOut trails the pop by one cycle, so compare with the previous index
        assign expByte  = uartRxPkg::bistPattern
                          ^ uartRxPkg::byteBits'(fifoWidth'(idx - 1'b1));
        assign byteBad  = (dataOut != expByte);

        assign bistBusy = (phase != phIdle);
        assign bistMode = bistBusy;                     // FIFO follows the test strobes
        assign testWr   = (phase == phWrite);
        assign testPop  = (phase == phPop);
        assign bistPass = bistDone && !failReg;

        ////////////////////////////////////////
        // Sequencer
        ////////////////////////////////////////

        always_ff @(posedge Data_Rdy or posedge Pop_Data) begin
                if (Pop_Data) begin
                        phase    <= phIdle;
                        idx      <= '0;
                        failReg  <= 1'b0;
                        bistDone <= 1'b0;
                end else begin
                        case (phase)
                        phIdle: if (bistStart) begin
                                phase    <= phWrite;
                                idx      <= '0;
                                failReg  <= 1'b0;
                                bistDone <= 1'b0;       // Cleared on restart only
                        end
                        phWrite: begin
                                idx <= idx + 1'b1;
                                if (&idx)
                                        phase <= phCheck;       // idx wraps back to zero
                        end
                        phCheck: begin
                                if (!fifoFull || fifoEmpty)
                                        failReg <= 1'b1;
                                phase <= phPop;
                        end
                        phPop: begin
                                // First pop has no byte out yet
                                if (idx != '0 && byteBad)
                                        failReg <= 1'b1;
                                idx <= idx + 1'b1;
                                if (&idx)
                                        phase <= phCmp;
                        end
                        phCmp: begin
                                if (byteBad)
                                        failReg <= 1'b1;        // Last entry
                                phase <= phEnd;
                        end
                        phEnd: begin
                                if (!fifoEmpty)
                                        failReg <= 1'b1;
                                bistDone <= 1'b1;
                                phase    <= phIdle;
                        end
                        default: phase <= phIdle;
                        endcase
                end
        end

endmodule

/* run.sh */
#!/bin/sh
# Build the receiver testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --assert -j 0 -f sim.f --top-module tbUartRx -o simUartRx &&
./obj_dir/simUartRx | tee /dev/stderr | grep -q "Test passed" &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }

/* rxFifo.sv */
module rxFifo #(
        parameter int fifoWidth = 4
) (
        input  logic                           Data_Rdy,
        input  logic                           Pop_Data,
        input  logic [uartRxPkg::byteBits-1:0] rxByte,
        input  logic                           rxStrobe,
        input  logic                           popReq,
        input  logic                           bistMode,
        input  logic                           testWr,
        input  logic [uartRxPkg::byteBits-1:0] testData,
        input  logic                           testPop,
        output logic [uartRxPkg::byteBits-1:0] dataOut,
        output logic                           fifoEmpty,
        output logic                           fifoHalf,
        output logic                           fifoFull,
        output logic                           fifoOverrun
);

        localparam int entries = 1 << fifoWidth;
        localparam logic [fifoWidth:0] fullCnt = (fifoWidth + 1)'(entries);
        localparam logic [fifoWidth:0] halfCnt = (fifoWidth + 1)'(entries / 2);

        logic [uartRxPkg::byteBits-1:0] mem [entries];
        logic [fifoWidth-1:0] wrPtr, rdPtr;
        logic [fifoWidth:0] count, countNext;           // One bit wider, holds a full count
        logic wrSel, popSel;                            // Strobes after source selection
        logic doWr, doPop;                              // Strobes that actually take effect
        logic [uartRxPkg::byteBits-1:0] wrByte;

        ////////////////////////////////////////
        // Source select and next count
        ////////////////////////////////////////

        always_comb begin
                wrSel  = bistMode ? testWr : rxStrobe;          // Self-test owns the FIFO
                popSel = bistMode ? testPop : popReq;
                wrByte = bistMode ? testData : rxByte;
                doWr   = wrSel && (count != fullCnt);           // Full drops the byte
                doPop  = popSel && (count != '0);               // Empty pop is a no-op
                countNext = count;
                if (doWr && !doPop)
                        countNext = count + 1'b1;
                else if (doPop && !doWr)
                        countNext = count - 1'b1;
        end

        always_ff @(posedge Data_Rdy) begin
                if (doWr)
                        mem[wrPtr] <= wrByte;
        end

        ////////////////////////////////////////
        // Pointers, output byte and flags
        ////////////////////////////////////////

        always_ff @(posedge Data_Rdy or posedge Pop_Data) begin
                if (Pop_Data) begin
                        wrPtr       <= '0;
                        rdPtr       <= '0;
                        count       <= '0;
                        dataOut     <= '0;
                        fifoEmpty   <= 1'b1;
                        fifoHalf    <= 1'b0;
                        fifoFull    <= 1'b0;
                        fifoOverrun <= 1'b0;
                end else begin
                        if (doWr)
                                wrPtr <= wrPtr + 1'b1;          // Wraps at the entry count
                        if (doPop) begin
                                dataOut <= mem[rdPtr];          // Held until the next pop
                                rdPtr   <= rdPtr + 1'b1;
                        end
                        count     <= countNext;
                        fifoEmpty <= (countNext == '0);
                        fifoHalf  <= (countNext >= halfCnt);    // At least half full
                        fifoFull  <= (countNext == fullCnt);

                        // Sticky until a pop makes room
                        if (wrSel && !doWr)
                                fifoOverrun <= 1'b1;
                        else if (doPop)
                                fifoOverrun <= 1'b0;
                end
        end

endmodule

/* sim.f */
uartRxPkg.sv
uartRx.sv
rxFifo.sv
fifoBist.sv
uartRxTop.sv
tbUartRx.sv

/* tbUartRx.sv */
module tbUartRx;

        localparam int clksPerBit    = 16;
        localparam int fifoWidth     = 4;
        localparam int entries       = 1 << fifoWidth;
        localparam int byteCycles    = 11 * clksPerBit;         // Start, 8 data, stop, idle bit
        localparam int timeoutCycles = 60 * byteCycles + 500;
        localparam int bistCycles    = 2 * entries + 3;         // Writes, check, pops, compare

        logic Data_Rdy;
        logic Pop_Data;
        logic rxd;
        logic popReq;
        logic bistStart;
        logic [uartRxPkg::byteBits-1:0] dataOut;
        logic fifoEmpty;
        logic fifoHalf;
        logic fifoFull;
        logic fifoOverrun;
        logic frameErr;
        logic bistBusy;
        logic bistDone;
        logic bistPass;

        int cycleCnt;                                   // Cycles since time zero
        logic sawFrameErr;                              // frameErr seen during the last frame
        logic [uartRxPkg::byteBits-1:0] sent [$];       // Bytes still expected from the FIFO
        logic [uartRxPkg::byteBits-1:0] lastPopped;     // Byte the last good pop returned

        uartRxTop #(.clksPerBit(clksPerBit), .fifoWidth(fifoWidth)) i_uartRxTop (
                .Data_Rdy    (Data_Rdy),
                .Pop_Data    (Pop_Data),
                .rxd         (rxd),
                .popReq      (popReq),
                .bistStart   (bistStart),
                .dataOut     (dataOut),
                .fifoEmpty   (fifoEmpty),
                .fifoHalf    (fifoHalf),
                .fifoFull    (fifoFull),
                .fifoOverrun (fifoOverrun),
                .frameErr    (frameErr),
                .bistBusy    (bistBusy),
                .bistDone    (bistDone),
                .bistPass    (bistPass)
        );

        always #20 Data_Rdy = ~Data_Rdy;                // 40 unit period

        always @(posedge Data_Rdy) begin
                cycleCnt = cycleCnt + 1;
                if (cycleCnt == timeoutCycles)
                        abortRun($sformatf("run still going after %0d cycles", timeoutCycles));
        end

        ////////////////////////////////////////
        // Check helpers
        ////////////////////////////////////////

        task automatic abortRun(input string why);
                $display("%s", why);
                $display("Test failed");
                $fatal(1);
        endtask

        task automatic checkByte(input string name, input logic [7:0] got, input logic [7:0] exp);
                assert (got === exp) else
                        abortRun($sformatf("mismatch at %0t: %s is %02h, expected %02h",
                                           $time, name, got, exp));
        endtask

        task automatic checkFlag(input string name, input logic got, input logic exp);
                assert (got === exp) else
                        abortRun($sformatf("mismatch at %0t: %s is %b, expected %b",
                                           $time, name, got, exp));
        endtask

        ////////////////////////////////////////
        // Serial line and pop drivers
        ////////////////////////////////////////

        // One bit time on the line, frameErr watched at every falling edge
        task automatic holdBit(input logic level);
                int n;
                rxd = level;
                for (n = 0; n < clksPerBit; n++) begin
                        @(negedge Data_Rdy);
                        if (frameErr)
                                sawFrameErr = 1'b1;
                end
        endtask

        task automatic sendByte(input logic [7:0] value, input logic goodStop);
                int i;
                sawFrameErr = 1'b0;
                holdBit(1'b0);                          // Start bit
                for (i = 0; i < 8; i++)
                        holdBit(value[i]);              // LSB first
                holdBit(goodStop);
                holdBit(1'b1);                          // Idle gap, a false start dies here
                assert (sawFrameErr == !goodStop) else
                        abortRun(goodStop ? "frameErr pulsed on a frame with a good stop bit"
                                          : "no frameErr pulse for a frame with a low stop bit");
        endtask

        // dataOut is loaded at the edge that samples popReq
        task automatic popCheck(input logic [7:0] exp);
                popReq = 1'b1;
                @(negedge Data_Rdy);
                popReq = 1'b0;
                checkByte("dataOut", dataOut, exp);
                lastPopped = exp;
        endtask

        ////////////////////////////////////////
        // Directed tests
        ////////////////////////////////////////

        task automatic resetCheck();
                checkFlag("fifoEmpty", fifoEmpty, 1'b1);
                checkFlag("fifoHalf", fifoHalf, 1'b0);
                checkFlag("fifoFull", fifoFull, 1'b0);
                checkFlag("fifoOverrun", fifoOverrun, 1'b0);
                checkFlag("bistBusy", bistBusy, 1'b0);
                checkFlag("bistDone", bistDone, 1'b0);
                checkFlag("bistPass", bistPass, 1'b0);
                checkByte("dataOut", dataOut, 8'h00);
        endtask

        task automatic orderTest();
                logic [7:0] b;
                int k;
                for (k = 0; k < 5; k++) begin
                        b = 8'($urandom());
                        sent.push_back(b);
                        sendByte(b, 1'b1);
                        if (k == 0)
                                checkFlag("fifoEmpty", fifoEmpty, 1'b0);
                end
                while (sent.size() > 0)
                        popCheck(sent.pop_front());     // Same order as sent
                checkFlag("fifoEmpty", fifoEmpty, 1'b1);
        endtask

        task automatic capacityTest();
                logic [7:0] b;
                int k;
                for (k = 1; k <= entries; k++) begin
                        b = 8'($urandom());
                        sent.push_back(b);
                        sendByte(b, 1'b1);
                        checkFlag("fifoHalf", fifoHalf, k >= entries / 2);
                        checkFlag("fifoFull", fifoFull, k == entries);
                        checkFlag("fifoOverrun", fifoOverrun, 1'b0);
                end
                sendByte(8'($urandom()), 1'b1);         // No room, dropped
                checkFlag("fifoOverrun", fifoOverrun, 1'b1);
                checkFlag("fifoFull", fifoFull, 1'b1);
                popCheck(sent.pop_front());
                checkFlag("fifoOverrun", fifoOverrun, 1'b0);    // Cleared by the pop
                checkFlag("fifoFull", fifoFull, 1'b0);
                while (sent.size() > 0)
                        popCheck(sent.pop_front());
                checkFlag("fifoEmpty", fifoEmpty, 1'b1);
        endtask

        task automatic frameErrTest();
                logic [7:0] b;
                sendByte(8'($urandom()), 1'b0);         // Low stop bit
                checkFlag("fifoEmpty", fifoEmpty, 1'b1);
                b = 8'($urandom());
                sendByte(b, 1'b1);
                checkFlag("fifoEmpty", fifoEmpty, 1'b0);
                popCheck(b);
                checkFlag("fifoEmpty", fifoEmpty, 1'b1);
        endtask

        // FIFO is drained, so every flag but empty is low
        task automatic emptyPopTest();
                popReq = 1'b1;
                @(negedge Data_Rdy);
                popReq = 1'b0;
                @(negedge Data_Rdy);
                checkByte("dataOut", dataOut, lastPopped);      // Byte from the last good pop
                checkFlag("fifoEmpty", fifoEmpty, 1'b1);
                checkFlag("fifoHalf", fifoHalf, 1'b0);
                checkFlag("fifoFull", fifoFull, 1'b0);
                checkFlag("fifoOverrun", fifoOverrun, 1'b0);
        endtask

        task automatic bistTest();
                logic [7:0] b;
                int cyc;
                int k;
                bistStart = 1'b1;
                @(negedge Data_Rdy);
                bistStart = 1'b0;
                checkFlag("bistBusy", bistBusy, 1'b1);
                checkFlag("bistDone", bistDone, 1'b0);
                cyc = 0;
                while (!bistDone && cyc < bistCycles) begin
                        @(negedge Data_Rdy);
                        cyc++;
                end
                assert (bistDone) else
                        abortRun($sformatf("self-test not done within %0d cycles", bistCycles));
                checkFlag("bistBusy", bistBusy, 1'b0);
                checkFlag("bistPass", bistPass, 1'b1);
                checkFlag("fifoEmpty", fifoEmpty, 1'b1);
                // Receive path must be back in charge of the FIFO
                for (k = 0; k < 2; k++) begin
                        b = 8'($urandom());
                        sendByte(b, 1'b1);
                        popCheck(b);
                end
                checkFlag("bistDone", bistDone, 1'b1);  // Held until the next start
        endtask

        initial begin
                Data_Rdy    = 1'b0;
                Pop_Data    = 1'b1;
                rxd         = 1'b1;                     // Line idles high
                popReq      = 1'b0;
                bistStart   = 1'b0;
                cycleCnt    = 0;
                sawFrameErr = 1'b0;
                lastPopped  = '0;                       // dataOut after reset
                void'($urandom(32'h81db_1dab));
                repeat (10) @(negedge Data_Rdy);
                Pop_Data = 1'b0;
                resetCheck();
                orderTest();
                capacityTest();
                frameErrTest();
                emptyPopTest();
                bistTest();
                $display("Test passed");
                $finish;
        end

endmodule

/* uartRx.sv */
module uartRx #(
        parameter int clksPerBit = 16
) (
        input  logic                           Data_Rdy,
        input  logic                           Pop_Data,
        input  logic                           rxd,
        output logic [uartRxPkg::byteBits-1:0] rxByte,
        output logic                           rxStrobe,
        output logic                           frameErr
);

        localparam int cntBits = $clog2(clksPerBit);
        localparam int bitIdxBits = $clog2(uartRxPkg::byteBits);
        localparam logic [cntBits-1:0] lastTick = cntBits'(clksPerBit - 1);
        localparam logic [cntBits-1:0] midTick = cntBits'(clksPerBit / 2 - 1);
        localparam logic [bitIdxBits-1:0] lastBit = bitIdxBits'(uartRxPkg::byteBits - 1);

        uartRxPkg::rxState state;
        logic rxMeta;                                   // First sync stage
        logic rxSync;                                   // Line, safe to use
        logic [cntBits-1:0] tickCnt;                    // Clocks within the current bit
        logic [bitIdxBits-1:0] bitCnt;                  // Data bit being sampled
        logic [uartRxPkg::byteBits-1:0] shiftReg;

        ////////////////////////////////////////
        // Input synchronizer
        ////////////////////////////////////////

        always_ff @(posedge Data_Rdy or posedge Pop_Data) begin
                if (Pop_Data) begin
                        rxMeta <= 1'b1;                 // Line idles high
                        rxSync <= 1'b1;
                end else begin
                        rxMeta <= rxd;
                        rxSync <= rxMeta;
                end
        end

        ////////////////////////////////////////
        // Bit timing FSM
        ////////////////////////////////////////

        always_ff @(posedge Data_Rdy or posedge Pop_Data) begin
                if (Pop_Data) begin
                        state    <= uartRxPkg::idle;
                        tickCnt  <= '0;
                        bitCnt   <= '0;
                        rxStrobe <= 1'b0;
                        frameErr <= 1'b0;
                end else begin
                        rxStrobe <= 1'b0;               // Pulses last one cycle
                        frameErr <= 1'b0;
                        case (state)
                        uartRxPkg::idle: begin
                                tickCnt <= '0;
                                if (!rxSync)
                                        state <= uartRxPkg::start;      // Possible start bit
                        end
                        uartRxPkg::start: begin
                                if (tickCnt == midTick) begin
                                        tickCnt <= '0;
                                        bitCnt  <= '0;
                                        // A glitch is back high by the middle
                                        state <= rxSync ? uartRxPkg::idle : uartRxPkg::data;
                                end else begin
                                        tickCnt <= tickCnt + 1'b1;
                                end
                        end
                        uartRxPkg::data: begin
                                if (tickCnt == lastTick) begin      // Middle of a data bit
                                        tickCnt <= '0;
                                        bitCnt  <= bitCnt + 1'b1;
                                        if (bitCnt == lastBit)
                                                state <= uartRxPkg::stop;
                                end else begin
                                        tickCnt <= tickCnt + 1'b1;
                                end
                        end
                        uartRxPkg::stop: begin
                                if (tickCnt == lastTick) begin
                                        rxStrobe <= rxSync;     // Good frame
                                        frameErr <= !rxSync;    // Byte dropped
                                        state    <= uartRxPkg::idle;
                                end else begin
                                        tickCnt <= tickCnt + 1'b1;
                                end
                        end
                        default: state <= uartRxPkg::idle;
                        endcase
                end
        end

        // LSB arrives first, so shift in from the top
        always_ff @(posedge Data_Rdy) begin
                if (state == uartRxPkg::data && tickCnt == lastTick)
                        shiftReg <= {rxSync, shiftReg[uartRxPkg::byteBits-1:1]};
        end

        assign rxByte = shiftReg;                       // Stable while rxStrobe is high

endmodule

/* uartRxPkg.sv */
package uartRxPkg;

        ////////////////////////////////////////
        // Shared widths and constants
        ////////////////////////////////////////

        localparam int byteBits = 8;                    // One serial data byte

        // Self-test writes this XOR the entry index into each entry
        localparam logic [byteBits-1:0] bistPattern = 8'hA5;

        ////////////////////////////////////////
        // Receiver FSM states
        ////////////////////////////////////////

        typedef enum logic [1:0] {
                idle,                                   // Line high, waiting for a falling edge
                start,                                  // Timing out to the start-bit middle
                data,                                   // Sampling the eight data bits
                stop                                    // Sampling the stop bit
        } rxState;

endpackage

/* uartRxTop.sv */
module uartRxTop #(
        parameter int clksPerBit = 16,
        parameter int fifoWidth  = 4
) (
        input  logic                           Data_Rdy,
        input  logic                           Pop_Data,
        input  logic                           rxd,
        input  logic                           popReq,
        input  logic                           bistStart,
        output logic [uartRxPkg::byteBits-1:0] dataOut,
        output logic                           fifoEmpty,
        output logic                           fifoHalf,
        output logic                           fifoFull,
        output logic                           fifoOverrun,
        output logic                           frameErr,
        output logic                           bistBusy,
        output logic                           bistDone,
        output logic                           bistPass
);

        logic [uartRxPkg::byteBits-1:0] rxByte;        // Receiver to FIFO
        logic                           rxStrobe;
        logic                           bistMode;      // Self-test to FIFO
        logic                           testWr;
        logic                           testPop;
        logic [uartRxPkg::byteBits-1:0] testData;

        uartRx #(.clksPerBit(clksPerBit)) i_uartRx (
                .Data_Rdy (Data_Rdy),
                .Pop_Data (Pop_Data),
                .rxd      (rxd),
                .rxByte   (rxByte),
                .rxStrobe (rxStrobe),
                .frameErr (frameErr)
        );

        rxFifo #(.fifoWidth(fifoWidth)) i_rxFifo (
                .Data_Rdy    (Data_Rdy),
                .Pop_Data    (Pop_Data),
                .rxByte      (rxByte),
                .rxStrobe    (rxStrobe),
                .popReq      (popReq),
                .bistMode    (bistMode),
                .testWr      (testWr),
                .testData    (testData),
                .testPop     (testPop),
                .dataOut     (dataOut),
                .fifoEmpty   (fifoEmpty),
                .fifoHalf    (fifoHalf),
                .fifoFull    (fifoFull),
                .fifoOverrun (fifoOverrun)
        );

        // Reads the FIFO back through its normal output
        fifoBist #(.fifoWidth(fifoWidth)) i_fifoBist (
                .Data_Rdy  (Data_Rdy),
                .Pop_Data  (Pop_Data),
                .bistStart (bistStart),
                .dataOut   (dataOut),
                .fifoEmpty (fifoEmpty),
                .fifoFull  (fifoFull),
                .bistMode  (bistMode),
                .testWr    (testWr),
                .testData  (testData),
                .testPop   (testPop),
                .bistBusy  (bistBusy),
                .bistDone  (bistDone),
                .bistPass  (bistPass)
        );

endmodule
